// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --assert --timescale 1ns/1ps -j 0
TOP       = rv_pipeline_tb
FILELIST  = tb.f
LOG       = sim.log

.PHONY: simulate clean

simulate:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "ALL TESTS PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// File: design/decode_stage.sv
`include "rv_defines.svh"

module decode_stage (
    input  logic                     clk,
    input  logic                     arst_n,
    input  logic                     flush,
    input  rv_isa_pkg::word_t        id_instr,
    input  rv_isa_pkg::word_t        id_pc,
    input  logic                     wb_en,       // Write strobe from MEM/WB
    input  rv_isa_pkg::reg_idx_t     wb_rd,
    input  rv_isa_pkg::word_t        wb_data,
    output rv_isa_pkg::word_t        ex_pc,
    output rv_isa_pkg::word_t        ex_rs1_data,
    output rv_isa_pkg::word_t        ex_rs2_data,
    output rv_isa_pkg::word_t        ex_imm,
    output rv_isa_pkg::reg_idx_t     ex_rs1,
    output rv_isa_pkg::reg_idx_t     ex_rs2,
    output rv_isa_pkg::reg_idx_t     ex_rd,
    output logic [9:0]               ex_funct,    // funct7 above funct3
    output rv_ctrl_pkg::alu_class_e  ex_alu_class,
    output logic                     ex_alu_src,
    output logic                     ex_branch,
    output logic                     ex_jump,
    output logic                     ex_mem_read,
    output logic                     ex_mem_write,
    output logic                     ex_reg_write
);
    import rv_isa_pkg::*;
    import rv_ctrl_pkg::*;

    word_t      regs [`RV_REG_COUNT];
    reg_idx_t   rs1, rs2, rd;
    word_t      rs1_data, rs2_data;
    word_t      imm;
    opcode_e    opcode;
    alu_class_e alu_class;
    logic       alu_src, branch, jump, mem_read, mem_write, reg_write;

    assign opcode = opcode_e'(id_instr[6:0]);
    assign rd     = id_instr[11:7];
    assign rs1    = id_instr[19:15];
    assign rs2    = id_instr[24:20];

    // ============================================================
    // Register file
    // ============================================================
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < `RV_REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_en) begin
            regs[wb_rd] <= wb_data;        // wb_en never set for x0
        end
    end

    // x0 reads zero, same-cycle write bypassed
    assign rs1_data = (rs1 == '0) ? '0 : (wb_en && wb_rd == rs1) ? wb_data : regs[rs1];
    assign rs2_data = (rs2 == '0) ? '0 : (wb_en && wb_rd == rs2) ? wb_data : regs[rs2];

    // Immediate generator
    always_comb begin
        case (opcode)
            OPC_STORE:  imm = {{20{id_instr[31]}}, id_instr[31:25], id_instr[11:7]};
            OPC_BRANCH: imm = {{19{id_instr[31]}}, id_instr[31], id_instr[7],
                               id_instr[30:25], id_instr[11:8], 1'b0};
            OPC_JAL:    imm = {{11{id_instr[31]}}, id_instr[31], id_instr[19:12],
                               id_instr[20], id_instr[30:21], 1'b0};
            default:    imm = {{20{id_instr[31]}}, id_instr[31:20]};   // I format
        endcase
    end

    // Main decoder
    always_comb begin
        alu_class = CLS_MEM_ADD;
        alu_src   = 1'b0;
        branch    = 1'b0;
        jump      = 1'b0;
        mem_read  = 1'b0;
        mem_write = 1'b0;
        reg_write = 1'b0;
        case (opcode)
            OPC_OP: begin
                alu_class = CLS_REG;
                reg_write = 1'b1;
            end
            OPC_OP_IMM: begin
                alu_class = CLS_IMM;
                alu_src   = 1'b1;
                reg_write = 1'b1;
            end
            OPC_LOAD: begin
                alu_src   = 1'b1;
                mem_read  = 1'b1;
                reg_write = 1'b1;
            end
            OPC_STORE: begin
                alu_src   = 1'b1;
                mem_write = 1'b1;
            end
            OPC_BRANCH: begin
                alu_class = CLS_BRANCH;
                branch    = 1'b1;
            end
            OPC_JAL: begin
                jump      = 1'b1;          // Link written as pc+4
                reg_write = 1'b1;
            end
            default: ;                     // Unknown opcode acts as bubble
        endcase
    end

    // ============================================================
    // ID/EX register
    // ============================================================
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ex_branch    <= 1'b0;
            ex_jump      <= 1'b0;
            ex_mem_read  <= 1'b0;
            ex_mem_write <= 1'b0;
            ex_reg_write <= 1'b0;
        end else begin                     // Flush turns the slot into a bubble
            ex_branch    <= branch && !flush;
            ex_jump      <= jump && !flush;
            ex_mem_read  <= mem_read && !flush;
            ex_mem_write <= mem_write && !flush;
            ex_reg_write <= reg_write && (rd != '0) && !flush;   // x0 writes dropped here
        end
    end

    always_ff @(posedge clk) begin
        ex_pc        <= id_pc;
        ex_rs1_data  <= rs1_data;
        ex_rs2_data  <= rs2_data;
        ex_imm       <= imm;
        ex_rs1       <= rs1;
        ex_rs2       <= rs2;
        ex_rd        <= rd;
        ex_funct     <= {id_instr[31:25], id_instr[14:12]};
        ex_alu_class <= alu_class;
        ex_alu_src   <= alu_src;
    end

endmodule

// File: design/execute_stage.sv
`include "rv_defines.svh"

module execute_stage (
    input  logic                     clk,
    input  logic                     arst_n,
    input  logic                     flush,
    input  rv_isa_pkg::word_t        ex_pc,
    input  rv_isa_pkg::word_t        ex_rs1_data,
    input  rv_isa_pkg::word_t        ex_rs2_data,
    input  rv_isa_pkg::word_t        ex_imm,
    input  rv_isa_pkg::reg_idx_t     ex_rs1,
    input  rv_isa_pkg::reg_idx_t     ex_rs2,
    input  rv_isa_pkg::reg_idx_t     ex_rd,
    input  logic [9:0]               ex_funct,
    input  rv_ctrl_pkg::alu_class_e  ex_alu_class,
    input  logic                     ex_alu_src,
    input  logic                     ex_branch,
    input  logic                     ex_jump,
    input  logic                     ex_mem_read,
    input  logic                     ex_mem_write,
    input  logic                     ex_reg_write,
    input  rv_isa_pkg::word_t        mem_fwd_data,   // EX/MEM result
    input  rv_isa_pkg::reg_idx_t     mem_rd,
    input  logic                     mem_regwrite,
    input  logic                     wb_en,          // MEM/WB forwarding source
    input  rv_isa_pkg::reg_idx_t     wb_rd,
    input  rv_isa_pkg::word_t        wb_data,
    output rv_isa_pkg::word_t        mem_result,
    output rv_isa_pkg::word_t        mem_store_data,
    output rv_isa_pkg::word_t        mem_target,
    output logic                     mem_zero,
    output logic                     mem_branch,
    output logic                     mem_jump,
    output logic                     mem_read,
    output logic                     mem_write,
    output logic                     mem_reg_write_q,
    output rv_isa_pkg::reg_idx_t     mem_rd_q
);
    import rv_isa_pkg::*;
    import rv_ctrl_pkg::*;

    word_t   op_a, rs2_fwd, op_b;
    word_t   alu_res, result;
    alu_op_e alu_op;
    logic [2:0] funct3;

    // EX/MEM wins over MEM/WB, x0 never forwarded
    function automatic word_t fwd_operand(input reg_idx_t rs, input word_t id_val);
        word_t val;
        val = id_val;
        if (mem_regwrite && mem_rd != '0 && mem_rd == rs) begin
            val = mem_fwd_data;
        end else if (wb_en && wb_rd != '0 && wb_rd == rs) begin
            val = wb_data;
        end
        return val;
    endfunction

    always_comb begin
        op_a    = fwd_operand(ex_rs1, ex_rs1_data);
        rs2_fwd = fwd_operand(ex_rs2, ex_rs2_data);   // Also the sw data
    end

    assign op_b = ex_alu_src ? ex_imm : rs2_fwd;

    // ============================================================
    // ALU control
    // ============================================================
    assign funct3 = ex_funct[2:0];

    always_comb begin
        case (ex_alu_class)
            CLS_MEM_ADD: alu_op = ALU_ADD;
            CLS_BRANCH:  alu_op = ALU_SUB;
            default: begin
                case (funct3)
                    // funct7 bit 5 selects sub only for register form
                    3'b000:  alu_op = (ex_alu_class == CLS_REG && ex_funct[8]) ? ALU_SUB
                                                                              : ALU_ADD;
                    3'b001:  alu_op = ALU_SLL;
                    3'b010:  alu_op = ALU_SLT;
                    3'b100:  alu_op = ALU_XOR;
                    3'b101:  alu_op = ex_funct[8] ? ALU_SRA : ALU_SRL;
                    3'b110:  alu_op = ALU_OR;
                    default: alu_op = ALU_AND;
                endcase
            end
        endcase
    end

    // ALU proper
    always_comb begin
        case (alu_op)
            ALU_SUB: alu_res = op_a - op_b;
            ALU_AND: alu_res = op_a & op_b;
            ALU_OR:  alu_res = op_a | op_b;
            ALU_XOR: alu_res = op_a ^ op_b;
            ALU_SLT: alu_res = ($signed(op_a) < $signed(op_b)) ? `RV_XLEN'd1 : '0;
            ALU_SLL: alu_res = op_a << op_b[4:0];
            ALU_SRL: alu_res = op_a >> op_b[4:0];
            ALU_SRA: alu_res = $signed(op_a) >>> op_b[4:0];
            default: alu_res = op_a + op_b;
        endcase
    end

    assign result = ex_jump ? ex_pc + `RV_XLEN'd4 : alu_res;   // jal link

    // ============================================================
    // EX/MEM register
    // ============================================================
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            mem_branch      <= 1'b0;
            mem_jump        <= 1'b0;
            mem_read        <= 1'b0;
            mem_write       <= 1'b0;
            mem_reg_write_q <= 1'b0;
        end else begin                        // Squashed slot leaves as a bubble
            mem_branch      <= ex_branch && !flush;
            mem_jump        <= ex_jump && !flush;
            mem_read        <= ex_mem_read && !flush;
            mem_write       <= ex_mem_write && !flush;
            mem_reg_write_q <= ex_reg_write && !flush;
        end
    end

    always_ff @(posedge clk) begin
        mem_result     <= result;
        mem_store_data <= rs2_fwd;
        mem_target     <= ex_pc + ex_imm;     // Branch and jal target
        mem_zero       <= (alu_res == '0);
        mem_rd_q       <= ex_rd;
    end

endmodule

// File: design/fetch_stage.sv
`include "rv_defines.svh"

module fetch_stage (
    input  logic               clk,
    input  logic               arst_n,
    input  logic               redirect,      // Taken branch or jal in MEM
    input  rv_isa_pkg::word_t  redirect_pc,
    output rv_isa_pkg::word_t  imem_addr,
    input  rv_isa_pkg::word_t  imem_data,     // Returned in the same cycle
    output rv_isa_pkg::word_t  id_instr,
    output rv_isa_pkg::word_t  id_pc
);
    import rv_isa_pkg::*;

    word_t pc_q;
    word_t pc_next;

    // Sequential step unless MEM redirects
    assign pc_next   = redirect ? redirect_pc : pc_q + `RV_XLEN'd4;
    assign imem_addr = pc_q;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pc_q <= `RV_RESET_PC;
        end else begin
            pc_q <= pc_next;
        end
    end

    // ============================================================
    // IF/ID register
    // ============================================================
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            id_instr <= `RV_NOP;               // Start full of bubbles
        end else if (redirect) begin
            id_instr <= `RV_NOP;               // Squash wrong-path fetch
        end else begin
            id_instr <= imem_data;
        end
    end

    always_ff @(posedge clk) begin
        id_pc <= pc_q;
    end

endmodule

// File: design/memory_stage.sv
`include "rv_defines.svh"

module memory_stage (
    input  logic                  clk,
    input  logic                  arst_n,
    input  rv_isa_pkg::word_t     mem_result,      // ALU result, address or link
    input  rv_isa_pkg::word_t     mem_store_data,
    input  rv_isa_pkg::word_t     mem_target,
    input  logic                  mem_zero,
    input  logic                  mem_branch,
    input  logic                  mem_jump,
    input  logic                  mem_read,
    input  logic                  mem_write,
    input  logic                  mem_reg_write,
    input  rv_isa_pkg::reg_idx_t  mem_rd,
    output logic                  redirect,
    output rv_isa_pkg::word_t     redirect_pc,
    output rv_isa_pkg::word_t     fwd_data,
    output logic                  wb_en,
    output rv_isa_pkg::reg_idx_t  wb_rd,
    output rv_isa_pkg::word_t     wb_data
);
    import rv_isa_pkg::*;

    localparam int DMEM_AW = $clog2(`RV_DMEM_WORDS);

    word_t               dmem [`RV_DMEM_WORDS];
    logic [DMEM_AW-1:0]  dmem_idx;
    word_t               wb_load, wb_result;
    logic                wb_from_mem;

    assign dmem_idx = mem_result[DMEM_AW+1:2];   // Word index, wraps at depth

    // ============================================================
    // Data memory
    // ============================================================
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < `RV_DMEM_WORDS; i++) begin
                dmem[i] <= '0;
            end
        end else if (mem_write) begin
            dmem[dmem_idx] <= mem_store_data;
        end
    end

    // Branch resolution
    assign redirect    = mem_jump || (mem_branch && mem_zero);
    assign redirect_pc = mem_target;
    assign fwd_data    = mem_result;

    // MEM/WB register
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wb_en <= 1'b0;
        end else begin
            wb_en <= mem_reg_write;               // rd already nonzero
        end
    end

    always_ff @(posedge clk) begin
        wb_rd       <= mem_rd;
        wb_load     <= dmem[dmem_idx];
        wb_result   <= mem_result;
        wb_from_mem <= mem_read;
    end

    assign wb_data = wb_from_mem ? wb_load : wb_result;   // Writeback select

endmodule

// File: design/rv_ctrl_pkg.sv
`include "rv_defines.svh"

package rv_ctrl_pkg;

    // Operations the ALU carries out
    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,    // Signed compare
        ALU_SLL,
        ALU_SRL,
        ALU_SRA
    } alu_op_e;

    // How ALU control interprets the funct fields
    typedef enum logic [1:0] {
        CLS_MEM_ADD,   // Load and store address
        CLS_BRANCH,    // beq compare by subtraction
        CLS_REG,       // funct7 and funct3 both matter
        CLS_IMM        // funct3 only
    } alu_class_e;

endpackage

// File: design/rv_defines.svh
`ifndef RV_DEFINES_SVH
`define RV_DEFINES_SVH

// ============================================================
// Core dimensions
// ============================================================
`define RV_XLEN       32    // Data and address width
`define RV_REG_COUNT  32    // Architectural registers x0 to x31

// Word-addressed data memory
`define RV_DMEM_WORDS 128

// ============================================================
// Fixed encodings
// ============================================================
`define RV_RESET_PC   32'h0000_0000   // First fetch address

// Encoding of addi x0 x0 0, the pipeline bubble
`define RV_NOP        32'h0000_0013

`endif

// File: design/rv_isa_pkg.sv
`include "rv_defines.svh"

package rv_isa_pkg;

    // One machine word
    typedef logic [`RV_XLEN-1:0] word_t;

    // Register index sized from the register count
    typedef logic [$clog2(`RV_REG_COUNT)-1:0] reg_idx_t;

    // ============================================================
    // Major opcodes of the supported classes
    // ============================================================
    typedef enum logic [6:0] {
        OPC_OP     = 7'b0110011,   // Register-register ALU
        OPC_OP_IMM = 7'b0010011,   // Register-immediate ALU
        OPC_LOAD   = 7'b0000011,   // lw only
        OPC_STORE  = 7'b0100011,   // sw only
        OPC_BRANCH = 7'b1100011,   // beq only
        OPC_JAL    = 7'b1101111
    } opcode_e;

endpackage

// File: design/rv_pipeline_cpu.sv
`include "rv_defines.svh"

module rv_pipeline_cpu (
    input  logic                  clk,
    input  logic                  arst_n,
    output rv_isa_pkg::word_t     imem_addr,
    input  rv_isa_pkg::word_t     imem_data,
    output logic                  wb_en,      // Retirement strobe
    output rv_isa_pkg::reg_idx_t  wb_rd,
    output rv_isa_pkg::word_t     wb_data
);
    import rv_isa_pkg::*;
    import rv_ctrl_pkg::*;

    // ============================================================
    // Stage to stage wiring
    // ============================================================
    logic       redirect;                            // Also the flush
    word_t      redirect_pc, fwd_data;
    word_t      id_instr, id_pc;                     // IF/ID
    word_t      ex_pc, ex_rs1_data, ex_rs2_data, ex_imm;
    reg_idx_t   ex_rs1, ex_rs2, ex_rd;
    logic [9:0] ex_funct;
    alu_class_e ex_alu_class;
    logic       ex_alu_src, ex_branch, ex_jump;
    logic       ex_mem_read, ex_mem_write, ex_reg_write;
    word_t      mem_result, mem_store_data, mem_target;
    logic       mem_zero, mem_branch, mem_jump;
    logic       mem_read, mem_write, mem_reg_write;
    reg_idx_t   mem_rd;

    fetch_stage fetch_stage_i (
        .clk(clk), .arst_n(arst_n),
        .redirect(redirect), .redirect_pc(redirect_pc),
        .imem_addr(imem_addr), .imem_data(imem_data),
        .id_instr(id_instr), .id_pc(id_pc)
    );

    decode_stage decode_stage_i (
        .clk(clk), .arst_n(arst_n), .flush(redirect),
        .id_instr(id_instr), .id_pc(id_pc),
        .wb_en(wb_en), .wb_rd(wb_rd), .wb_data(wb_data),
        .ex_pc(ex_pc), .ex_rs1_data(ex_rs1_data), .ex_rs2_data(ex_rs2_data),
        .ex_imm(ex_imm), .ex_rs1(ex_rs1), .ex_rs2(ex_rs2), .ex_rd(ex_rd),
        .ex_funct(ex_funct), .ex_alu_class(ex_alu_class), .ex_alu_src(ex_alu_src),
        .ex_branch(ex_branch), .ex_jump(ex_jump), .ex_mem_read(ex_mem_read),
        .ex_mem_write(ex_mem_write), .ex_reg_write(ex_reg_write)
    );

    // EX/MEM rd and write enable loop back for forwarding
    execute_stage execute_stage_i (
        .clk(clk), .arst_n(arst_n), .flush(redirect),
        .ex_pc(ex_pc), .ex_rs1_data(ex_rs1_data), .ex_rs2_data(ex_rs2_data),
        .ex_imm(ex_imm), .ex_rs1(ex_rs1), .ex_rs2(ex_rs2), .ex_rd(ex_rd),
        .ex_funct(ex_funct), .ex_alu_class(ex_alu_class), .ex_alu_src(ex_alu_src),
        .ex_branch(ex_branch), .ex_jump(ex_jump), .ex_mem_read(ex_mem_read),
        .ex_mem_write(ex_mem_write), .ex_reg_write(ex_reg_write),
        .mem_fwd_data(fwd_data), .mem_rd(mem_rd), .mem_regwrite(mem_reg_write),
        .wb_en(wb_en), .wb_rd(wb_rd), .wb_data(wb_data),
        .mem_result(mem_result), .mem_store_data(mem_store_data),
        .mem_target(mem_target), .mem_zero(mem_zero), .mem_branch(mem_branch),
        .mem_jump(mem_jump), .mem_read(mem_read), .mem_write(mem_write),
        .mem_reg_write_q(mem_reg_write), .mem_rd_q(mem_rd)
    );

    memory_stage memory_stage_i (
        .clk(clk), .arst_n(arst_n),
        .mem_result(mem_result), .mem_store_data(mem_store_data),
        .mem_target(mem_target), .mem_zero(mem_zero), .mem_branch(mem_branch),
        .mem_jump(mem_jump), .mem_read(mem_read), .mem_write(mem_write),
        .mem_reg_write(mem_reg_write), .mem_rd(mem_rd),
        .redirect(redirect), .redirect_pc(redirect_pc), .fwd_data(fwd_data),
        .wb_en(wb_en), .wb_rd(wb_rd), .wb_data(wb_data)
    );

endmodule

// File: tb.f
+incdir+design
design/rv_isa_pkg.sv
design/rv_ctrl_pkg.sv
design/fetch_stage.sv
design/decode_stage.sv
design/execute_stage.sv
design/memory_stage.sv
design/rv_pipeline_cpu.sv
verification/tb_clock_gen.sv
verification/rv_pipeline_assertions.sv
verification/rv_pipeline_tb.sv

// File: verification/rv_pipeline_assertions.sv
module rv_pipeline_assertions (
    input logic                  clk,
    input logic                  arst_n,
    input rv_isa_pkg::word_t     imem_addr,
    input logic                  wb_en,
    input rv_isa_pkg::reg_idx_t  wb_rd
);
    timeunit 1ns;
    timeprecision 1ps;

    int fail_count = 0;    // Read by the testbench top

    // ============================================================
    // Port rules of the core
    // ============================================================
    wb_quiet_in_reset: assert property (@(posedge clk) !arst_n |-> !wb_en)
        else begin
            fail_count++;
            $error("wb_en high while arst_n is low");
        end

    // x0 writes are dropped in decode, so never seen here
    wb_rd_nonzero: assert property (@(posedge clk) disable iff (!arst_n) wb_en |-> wb_rd != '0)
        else begin
            fail_count++;
            $error("wb_en high with wb_rd equal to x0");
        end

    imem_word_aligned: assert property (@(posedge clk) disable iff (!arst_n)
                                        imem_addr[1:0] == 2'b00)
        else begin
            fail_count++;
            $error("imem_addr not word aligned");
        end

endmodule

// File: verification/rv_pipeline_tb.sv
`include "rv_defines.svh"

module rv_pipeline_tb;
    timeunit 1ns;
    timeprecision 1ps;
    import rv_isa_pkg::*;

    localparam int NUM_INSTR       = 200;
    localparam int END_IDX         = NUM_INSTR;            // Slot of the final self-loop
    localparam int CLK_PERIOD      = 4;
    localparam int RESET_CYCLES    = 16;
    localparam int WATCHDOG_CYCLES = NUM_INSTR * 4 + 100;
    localparam int DMEM_AW         = $clog2(`RV_DMEM_WORDS);
    localparam word_t END_PC       = word_t'(END_IDX * 4);

    // Instruction kinds of the generator
    localparam int K_ALU_R = 0;
    localparam int K_ALU_I = 1;
    localparam int K_LW    = 2;
    localparam int K_SW    = 3;
    localparam int K_BEQ   = 4;
    localparam int K_JAL   = 5;

    logic     clk;
    logic     arst_n;
    word_t    imem_addr;
    word_t    imem_data;
    logic     wb_en;
    reg_idx_t wb_rd;
    word_t    wb_data;

    // Program in field form, plus its encoding
    int       kind   [NUM_INSTR+1];
    int       sub_op [NUM_INSTR+1];    // ALU op index, add sub and or xor slt sll srl sra
    reg_idx_t rd_f   [NUM_INSTR+1];
    reg_idx_t rs1_f  [NUM_INSTR+1];
    reg_idx_t rs2_f  [NUM_INSTR+1];
    int       imm_f  [NUM_INSTR+1];
    word_t    prog   [NUM_INSTR+1];

    reg_idx_t exp_rd   [$];            // Expected writebacks in retire order
    word_t    exp_data [$];
    int       model_count  = 0;
    int       retire_count = 0;
    int       end_hits     = 0;
    int       seed         = 82009;

    tb_clock_gen #(.PERIOD_NS(CLK_PERIOD)) tb_clock_gen_i (.clk(clk));

    rv_pipeline_cpu rv_pipeline_cpu_i (
        .clk(clk), .arst_n(arst_n),
        .imem_addr(imem_addr), .imem_data(imem_data),
        .wb_en(wb_en), .wb_rd(wb_rd), .wb_data(wb_data)
    );

    bind rv_pipeline_cpu rv_pipeline_assertions rv_pipeline_assertions_i (
        .clk(clk), .arst_n(arst_n), .imem_addr(imem_addr), .wb_en(wb_en), .wb_rd(wb_rd)
    );

    function automatic int rand_below(input int n);
        return int'($unsigned($random(seed)) % n);
    endfunction

    // Source register, never the load destination just before
    function automatic reg_idx_t pick_src(input reg_idx_t avoid);
        reg_idx_t r;
        r = reg_idx_t'(rand_below(8));
        while (avoid != '0 && r == avoid) begin
            r = reg_idx_t'(rand_below(8));
        end
        return r;
    endfunction

    // funct7 bit 5 above funct3
    function automatic logic [3:0] r_fields(input int op);
        case (op)
            1:       return 4'b1_000;    // sub
            2:       return 4'b0_111;    // and
            3:       return 4'b0_110;    // or
            4:       return 4'b0_100;    // xor
            5:       return 4'b0_010;    // slt
            6:       return 4'b0_001;    // sll
            7:       return 4'b0_101;    // srl
            8:       return 4'b1_101;    // sra
            default: return 4'b0_000;    // add
        endcase
    endfunction

    // ============================================================
    // RV32I encodings
    // ============================================================
    function automatic word_t encode(input int i);
        logic [3:0]  f;
        logic [11:0] imm12;
        logic [12:0] imm13;
        logic [20:0] imm21;
        f     = r_fields(sub_op[i]);
        imm12 = imm_f[i][11:0];
        imm13 = imm_f[i][12:0];
        imm21 = imm_f[i][20:0];
        case (kind[i])
            K_ALU_R: return {1'b0, f[3], 5'b0, rs2_f[i], rs1_f[i], f[2:0], rd_f[i], 7'b0110011};
            K_ALU_I: return {imm12, rs1_f[i], f[2:0], rd_f[i], 7'b0010011};
            K_LW:    return {imm12, rs1_f[i], 3'b010, rd_f[i], 7'b0000011};
            K_SW:    return {imm12[11:5], rs2_f[i], rs1_f[i], 3'b010, imm12[4:0], 7'b0100011};
            K_BEQ:   return {imm13[12], imm13[10:5], rs2_f[i], rs1_f[i], 3'b000,
                             imm13[4:1], imm13[11], 7'b1100011};
            default: return {imm21[20], imm21[10:1], imm21[11], imm21[19:12],
                             rd_f[i], 7'b1101111};                      // jal
        endcase
    endfunction

    // Reference ALU from the instruction set rules
    function automatic word_t alu_ref(input int op, input word_t a, input word_t b);
        case (op)
            1:       return a - b;
            2:       return a & b;
            3:       return a | b;
            4:       return a ^ b;
            5:       return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            6:       return a << b[4:0];
            7:       return a >> b[4:0];
            8:       return word_t'($signed(a) >>> b[4:0]);
            default: return a + b;
        endcase
    endfunction

    task automatic build_program();
        reg_idx_t load_rd;
        int       pick;
        load_rd = '0;
        for (int i = 0; i < NUM_INSTR; i++) begin
            pick = rand_below((i <= END_IDX - 6) ? 10 : 8);   // Targets stay inside
            kind[i]   = (pick < 3) ? K_ALU_R : (pick < 5) ? K_ALU_I : (pick < 7) ? K_LW :
                        (pick == 7) ? K_SW : (pick == 8) ? K_BEQ : K_JAL;
            rd_f[i]   = reg_idx_t'(rand_below(8));
            rs1_f[i]  = pick_src(load_rd);
            rs2_f[i]  = pick_src(load_rd);
            sub_op[i] = 0;
            imm_f[i]  = 0;
            case (kind[i])
                K_ALU_R: sub_op[i] = rand_below(9);
                K_ALU_I: begin
                    pick      = rand_below(5);
                    sub_op[i] = (pick == 0) ? 0 : pick + 1;    // addi andi ori xori slti
                    imm_f[i]  = rand_below(4096) - 2048;
                end
                K_LW, K_SW: begin
                    rs1_f[i] = '0;                         // Absolute word address
                    imm_f[i] = 4 * rand_below(64);
                end
                K_BEQ: begin
                    if (rand_below(2) == 0) begin
                        rs2_f[i] = rs1_f[i];               // Sure to be taken
                    end
                    imm_f[i] = 4 * (2 + rand_below(5));
                end
                default: imm_f[i] = 4 * (2 + rand_below(5));
            endcase
            load_rd = (kind[i] == K_LW) ? rd_f[i] : '0;
            prog[i] = encode(i);
        end
        kind[END_IDX]   = K_JAL;                           // jal x0, 0
        sub_op[END_IDX] = 0;
        rd_f[END_IDX]   = '0;
        rs1_f[END_IDX]  = '0;
        rs2_f[END_IDX]  = '0;
        imm_f[END_IDX]  = 0;
        prog[END_IDX]   = encode(END_IDX);
    endtask

    // ============================================================
    // In-order reference model
    // ============================================================
    task automatic run_model();
        word_t             regs_m [`RV_REG_COUNT];
        word_t             dmem_m [`RV_DMEM_WORDS];
        word_t             a, b, val, addr;
        logic [DMEM_AW-1:0] widx;
        int                idx, next;
        logic              writes;
        for (int r = 0; r < `RV_REG_COUNT; r++) begin
            regs_m[r] = '0;
        end
        for (int w = 0; w < `RV_DMEM_WORDS; w++) begin
            dmem_m[w] = '0;                                // Unwritten words read zero
        end
        idx = 0;
        while (idx != END_IDX) begin
            a      = regs_m[rs1_f[idx]];
            b      = regs_m[rs2_f[idx]];
            addr   = a + word_t'(imm_f[idx]);
            widx   = addr[DMEM_AW+1:2];                    // Wraps at memory depth
            next   = idx + 1;
            val    = '0;
            writes = 1'b1;
            case (kind[idx])
                K_ALU_R: val = alu_ref(sub_op[idx], a, b);
                K_ALU_I: val = alu_ref(sub_op[idx], a, word_t'(imm_f[idx]));
                K_LW:    val = dmem_m[widx];
                K_SW: begin
                    dmem_m[widx] = b;
                    writes       = 1'b0;
                end
                K_BEQ: begin
                    if (a == b) begin
                        next = idx + imm_f[idx] / 4;
                    end
                    writes = 1'b0;
                end
                default: begin
                    val  = word_t'(idx * 4 + 4);           // Link is pc+4
                    next = idx + imm_f[idx] / 4;
                end
            endcase
            if (writes && rd_f[idx] != '0) begin
                regs_m[rd_f[idx]] = val;
                exp_rd.push_back(rd_f[idx]);
                exp_data.push_back(val);
            end
            idx = next;
        end
        model_count = exp_rd.size();
    endtask

    function automatic word_t fetch_word(input word_t addr);
        int widx;
        widx = int'(addr >> 2);
        if (addr[1:0] != 2'b00 || widx > END_IDX) begin
            return `RV_NOP;                                // Past the program
        end
        return prog[widx];
    endfunction

    task automatic stop_on_failure(input string why);
        $display("%s", why);
        $display("SOME TESTS FAILED");
        $fatal(1);
    endtask

    task automatic check_writeback(input reg_idx_t got_rd, input word_t got_data,
                                   input reg_idx_t want_rd, input word_t want_data);
        if (got_rd !== want_rd) begin
            $display("Error: wb_rd got 0x%h expected 0x%h", got_rd, want_rd);
            stop_on_failure("writeback register differs from the model");
        end else if (got_data !== want_data) begin
            $display("Error: wb_data got 0x%h expected 0x%h (rd x%0d)",
                     got_data, want_data, got_rd);
            stop_on_failure("writeback data differs from the model");
        end
    endtask

    task automatic check_retire_count(input int got, input int want);
        if (got != want) begin
            $display("Error: retire_count got 0x%h expected 0x%h", got, want);
            stop_on_failure("number of retirements differs from the model");
        end
    endtask

    // Instruction memory answers on the falling edge
    always @(negedge clk) begin
        imem_data = fetch_word(imem_addr);
    end

    initial begin
        #((RESET_CYCLES + WATCHDOG_CYCLES) * CLK_PERIOD);
        stop_on_failure("watchdog expired before the final self-loop was reached");
    end

    initial begin
        arst_n    = 1'b0;
        imem_data = `RV_NOP;
        build_program();
        run_model();
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;
        forever begin
            @(negedge clk);                                // Outputs settled mid-cycle
            if (rv_pipeline_cpu_i.rv_pipeline_assertions_i.fail_count != 0) begin
                stop_on_failure("a bound assertion on the core ports failed");
            end else if (wb_en) begin
                if (exp_rd.size() == 0) begin
                    stop_on_failure("writeback seen after the model ran out of results");
                end else begin
                    check_writeback(wb_rd, wb_data, exp_rd.pop_front(), exp_data.pop_front());
                    retire_count++;
                end
            end
            if (imem_addr == END_PC) begin
                end_hits++;
            end
            if (end_hits == 2) begin                       // Self-loop came round again
                break;
            end
        end
        check_retire_count(retire_count, model_count);
        if (exp_rd.size() != 0) begin
            stop_on_failure("model writebacks were never retired");
        end else begin
            $display("ALL TESTS PASSED");
            $finish;
        end
    end

endmodule

// File: verification/tb_clock_gen.sv
module tb_clock_gen #(
    parameter int PERIOD_NS = 4    // Full clock period
) (
    output logic clk
);
    timeunit 1ns;
    timeprecision 1ps;

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;    // Two equal phases
    end

endmodule
